/* disk_assembler.sv */
`default_nettype none

module disk_assembler import disk_pkg::*; #(
    parameter int MAX_BYTES = DEF_MAX_BYTES,
    localparam int LANE_W   = $clog2(MAX_BYTES)
) (
    input  logic                   clk,
    input  logic                   RST,
    input  logic                   fetch,
    input  logic [LANE_W-1:0]      fetch_lane,
    input  logic                   fetch_last,
    input  byte_t                  rd_byte,
    output logic [MAX_BYTES*8-1:0] data_out,
    output logic                   done
);

    logic                   byte_vld;
    logic [LANE_W-1:0]      byte_lane;
    logic                   byte_last;
    logic [MAX_BYTES*8-1:0] stage;
    logic [MAX_BYTES*8-1:0] stage_next;

    // Line the fetch tags up with the byte from the bank array.
    always_ff @(posedge clk) begin
        if (RST) begin
            byte_vld  <= 1'b0;
            byte_last <= 1'b0;
        end else begin
            byte_vld  <= fetch;
            byte_last <= fetch && fetch_last;
        end
    end

    always_ff @(posedge clk) begin
        byte_lane <= fetch_lane;
    end

    // Every read starts at lane 0, so that byte clears the old contents.
    always_comb begin
        stage_next = (byte_lane == '0) ? '0 : stage;
        stage_next[byte_lane*8 +: 8] = rd_byte;
    end

    always_ff @(posedge clk) begin
        if (byte_vld) begin
            stage <= stage_next;
        end
    end

    always_ff @(posedge clk) begin
        if (RST) begin
            data_out <= '0;
            done     <= 1'b0;
        end else begin
            done <= byte_vld && byte_last;
            if (byte_vld && byte_last) begin
                data_out <= stage_next;
            end
        end
    end

endmodule

`default_nettype wire

/* disk_bank.sv */
`default_nettype none

module disk_bank import disk_pkg::*; #(
    parameter int BANK_ADDR_W = DEF_BANK_ADDR_W
) (
    input  logic                   clk,
    input  logic                   we,
    input  logic [BANK_ADDR_W-1:0] waddr,
    input  byte_t                  wdata,
    input  logic                   re,
    input  logic [BANK_ADDR_W-1:0] raddr,
    output byte_t                  rdata
);

    localparam int DEPTH = 2 ** BANK_ADDR_W;

    byte_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // The read register keeps its byte while the bank is not selected.
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

/* disk_bank_array.sv */
`default_nettype none

module disk_bank_array import disk_pkg::*; #(
    parameter int BANK_ADDR_W = DEF_BANK_ADDR_W,
    parameter int NUM_BANKS   = DEF_NUM_BANKS,
    localparam int BANK_W     = $clog2(NUM_BANKS),
    localparam int ADDR_W     = BANK_ADDR_W + BANK_W
) (
    input  logic                   clk,
    input  logic                   RST,
    input  logic                   wr,
    input  logic [ADDR_W-1:0]      wr_addr,
    input  byte_t                  wr_data,
    input  logic                   fetch,
    input  logic [BANK_W-1:0]      fetch_bank,
    input  logic [BANK_ADDR_W-1:0] fetch_offset,
    output byte_t                  rd_byte
);

    logic [BANK_W-1:0]    wr_bank;
    logic [NUM_BANKS-1:0] bank_we;
    logic [NUM_BANKS-1:0] bank_re;
    logic [BANK_W-1:0]    rd_bank_q;
    byte_t                bank_rdata [NUM_BANKS];

    // The upper address bits select the bank.
    assign wr_bank = wr_addr[ADDR_W-1 -: BANK_W];

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        assign bank_we[b] = wr && (wr_bank == BANK_W'(b));
        assign bank_re[b] = fetch && (fetch_bank == BANK_W'(b));

        disk_bank #(
            .BANK_ADDR_W (BANK_ADDR_W)
        ) bank_i (
            .clk   (clk),
            .we    (bank_we[b]),
            .waddr (wr_addr[BANK_ADDR_W-1:0]),
            .wdata (wr_data),
            .re    (bank_re[b]),
            .raddr (fetch_offset),
            .rdata (bank_rdata[b])
        );
    end

    // The byte comes back one cycle after the fetch, so the mux
    // follows the bank number of the previous cycle.
    always_ff @(posedge clk) begin
        if (RST) begin
            rd_bank_q <= '0;
        end else if (fetch) begin
            rd_bank_q <= fetch_bank;
        end
    end

    assign rd_byte = bank_rdata[rd_bank_q];

    // Writes come from outside and fetches from the read controller.
    a_no_wr_during_fetch: assert property (
        @(posedge clk) disable iff (RST) !(wr && fetch)
    ) else $error("write strobe while a read is fetching");

endmodule

`default_nettype wire

/* disk_pkg.sv */
`default_nettype none

package disk_pkg;

    // One stored byte of the disk.
    typedef logic [7:0] byte_t;

    // Read controller states.
    // READ walks the first segment of a request.
    // READ_SPLIT walks the part that lies in the next bank.
    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        READ       = 2'd1,
        READ_SPLIT = 2'd2
    } read_state_t;

    // Offset width inside one bank, 256 bytes per bank.
    localparam int DEF_BANK_ADDR_W = 8;

    // Number of banks in the disk.
    localparam int DEF_NUM_BANKS = 8;

    // Largest block that one read returns.
    localparam int DEF_MAX_BYTES = 16;

endpackage

`default_nettype wire

/* disk_read_ctrl.sv */
`default_nettype none

module disk_read_ctrl import disk_pkg::*; #(
    parameter int BANK_ADDR_W = DEF_BANK_ADDR_W,
    parameter int NUM_BANKS   = DEF_NUM_BANKS,
    parameter int MAX_BYTES   = DEF_MAX_BYTES,
    localparam int BANK_W     = $clog2(NUM_BANKS),
    localparam int ADDR_W     = BANK_ADDR_W + BANK_W,
    localparam int SIZE_W     = $clog2(MAX_BYTES),
    localparam int LANE_W     = $clog2(MAX_BYTES)
) (
    input  logic                   clk,
    input  logic                   RST,
    input  logic                   rd_req,
    input  logic [ADDR_W-1:0]      rd_addr,
    input  logic [SIZE_W-1:0]      rd_size,
    output logic                   busy,
    output logic                   fetch,
    output logic [BANK_W-1:0]      fetch_bank,
    output logic [BANK_ADDR_W-1:0] fetch_offset,
    output logic [LANE_W-1:0]      fetch_lane,
    output logic                   fetch_last
);

    read_state_t            state;
    logic [ADDR_W-1:0]      end_addr;
    logic [BANK_W-1:0]      cur_bank;
    logic [BANK_ADDR_W-1:0] cur_off;
    logic [BANK_ADDR_W-1:0] end_off;
    logic [LANE_W:0]        lane_cnt;
    logic                   split_q;
    logic                   drain_q;
    logic                   at_bank_end;
    logic                   at_end;

    // Address of the last byte. It wraps past the last bank to bank 0.
    assign end_addr = rd_addr + ADDR_W'(rd_size);

    assign at_bank_end = (cur_off == '1);
    // In the first segment of a split read, end_off belongs to the next bank.
    assign at_end = (cur_off == end_off) && ((state == READ_SPLIT) || !split_q);

    always_ff @(posedge clk) begin
        if (RST) begin
            state   <= IDLE;
            drain_q <= 1'b0;
        end else begin
            drain_q <= fetch && fetch_last;
            case (state)
                IDLE: begin
                    if (rd_req) begin
                        state <= READ;
                    end
                end
                READ: begin
                    if (at_end) begin
                        state <= IDLE;
                    end else if (split_q && at_bank_end) begin
                        state <= READ_SPLIT;
                    end
                end
                READ_SPLIT: begin
                    if (at_end) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // The offset and lane step once per fetch. Leaving the first segment
    // moves to offset 0 of the next bank, and the lanes simply continue.
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            if (rd_req) begin
                cur_bank <= rd_addr[ADDR_W-1 -: BANK_W];
                cur_off  <= rd_addr[BANK_ADDR_W-1:0];
                end_off  <= end_addr[BANK_ADDR_W-1:0];
                split_q  <= end_addr[ADDR_W-1 -: BANK_W] != rd_addr[ADDR_W-1 -: BANK_W];
                lane_cnt <= '0;
            end
        end else begin
            cur_off  <= cur_off + 1'b1;
            lane_cnt <= lane_cnt + 1'b1;
            if (at_bank_end) begin
                cur_bank <= cur_bank + 1'b1;
            end
        end
    end

    assign fetch        = (state != IDLE);
    assign fetch_bank   = cur_bank;
    assign fetch_offset = cur_off;
    assign fetch_lane   = lane_cnt[LANE_W-1:0];
    assign fetch_last   = at_end;

    // The last byte is still in the bank array and the assembler for one cycle.
    assign busy = fetch || drain_q;

    a_no_req_while_busy: assert property (
        @(posedge clk) disable iff (RST) rd_req |-> !busy
    ) else $error("read request while the disk is busy");

    a_lane_in_range: assert property (
        @(posedge clk) disable iff (RST) fetch |-> (lane_cnt < MAX_BYTES)
    ) else $error("fetch lane beyond the result word");

endmodule

`default_nettype wire

/* disk_subsys.f */
disk_pkg.sv
disk_bank.sv
disk_bank_array.sv
disk_read_ctrl.sv
disk_assembler.sv
disk_subsys.sv
tb_disk_subsys.sv
+incdir+.

/* disk_subsys.sv */
`default_nettype none

module disk_subsys import disk_pkg::*; #(
    parameter int BANK_ADDR_W = DEF_BANK_ADDR_W,
    parameter int NUM_BANKS   = DEF_NUM_BANKS,
    parameter int MAX_BYTES   = DEF_MAX_BYTES,
    localparam int BANK_W     = $clog2(NUM_BANKS),
    localparam int ADDR_W     = BANK_ADDR_W + BANK_W,
    localparam int SIZE_W     = $clog2(MAX_BYTES),
    localparam int LANE_W     = $clog2(MAX_BYTES)
) (
    input  logic                   clk,
    input  logic                   RST,
    input  logic                   wr,
    input  logic [ADDR_W-1:0]      wr_addr,
    input  byte_t                  wr_data,
    input  logic                   rd_req,
    input  logic [ADDR_W-1:0]      rd_addr,
    input  logic [SIZE_W-1:0]      rd_size,
    output logic                   busy,
    output logic                   done,
    output logic [MAX_BYTES*8-1:0] data_out
);

    logic                   fetch;
    logic [BANK_W-1:0]      fetch_bank;
    logic [BANK_ADDR_W-1:0] fetch_offset;
    logic [LANE_W-1:0]      fetch_lane;
    logic                   fetch_last;
    byte_t                  rd_byte;

    disk_read_ctrl #(
        .BANK_ADDR_W (BANK_ADDR_W),
        .NUM_BANKS   (NUM_BANKS),
        .MAX_BYTES   (MAX_BYTES)
    ) ctrl_i (
        .clk          (clk),
        .RST          (RST),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .rd_size      (rd_size),
        .busy         (busy),
        .fetch        (fetch),
        .fetch_bank   (fetch_bank),
        .fetch_offset (fetch_offset),
        .fetch_lane   (fetch_lane),
        .fetch_last   (fetch_last)
    );

    disk_bank_array #(
        .BANK_ADDR_W (BANK_ADDR_W),
        .NUM_BANKS   (NUM_BANKS)
    ) banks_i (
        .clk          (clk),
        .RST          (RST),
        .wr           (wr),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .fetch        (fetch),
        .fetch_bank   (fetch_bank),
        .fetch_offset (fetch_offset),
        .rd_byte      (rd_byte)
    );

    disk_assembler #(
        .MAX_BYTES (MAX_BYTES)
    ) asm_i (
        .clk        (clk),
        .RST        (RST),
        .fetch      (fetch),
        .fetch_lane (fetch_lane),
        .fetch_last (fetch_last),
        .rd_byte    (rd_byte),
        .data_out   (data_out),
        .done       (done)
    );

endmodule

`default_nettype wire

/* tb_disk_checks.svh */
`ifndef TB_DISK_CHECKS_SVH
`define TB_DISK_CHECKS_SVH

// Compares a result word of the disk with its expected value.
task automatic check_data(
    input string                  name,
    input logic [MAX_BYTES*8-1:0] got,
    input logic [MAX_BYTES*8-1:0] exp
);
    if (got !== exp) begin
        $display("ERROR at time %0t: %s is %h, expected %h", $time, name, got, exp);
        report_failure();
    end
endtask

// Compares a single status bit such as busy or done.
task automatic check_flag(
    input string name,
    input logic  got,
    input logic  exp
);
    if (got !== exp) begin
        $display("ERROR at time %0t: %s is %b, expected %b", $time, name, got, exp);
        report_failure();
    end
endtask

`endif

/* tb_disk_subsys.sv */
`default_nettype none

module tb_disk_subsys import disk_pkg::*; ();

    localparam int BANK_ADDR_W     = DEF_BANK_ADDR_W;
    localparam int NUM_BANKS       = DEF_NUM_BANKS;
    localparam int MAX_BYTES       = DEF_MAX_BYTES;
    localparam int ADDR_W          = BANK_ADDR_W + $clog2(NUM_BANKS);
    localparam int SIZE_W          = $clog2(MAX_BYTES);
    localparam int BANK_BYTES      = 2 ** BANK_ADDR_W;
    localparam int DISK_BYTES      = BANK_BYTES * NUM_BANKS;
    localparam int DRIVE_DLY       = 2;
    localparam int RESET_CYCLES    = 4;
    localparam int NUM_ALIGNED     = 40;
    localparam int SPLITS_PER_BANK = 3;
    localparam int NUM_REWRITE     = 16;
    localparam int NUM_TESTS       = NUM_ALIGNED + NUM_BANKS * SPLITS_PER_BANK + NUM_REWRITE;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (MAX_BYTES + 10) + DISK_BYTES
                                     + RESET_CYCLES + 20;

    logic                   clk;
    logic                   RST;
    logic                   wr;
    logic [ADDR_W-1:0]      wr_addr;
    byte_t                  wr_data;
    logic                   rd_req;
    logic [ADDR_W-1:0]      rd_addr;
    logic [SIZE_W-1:0]      rd_size;
    logic                   busy;
    logic                   done;
    logic [MAX_BYTES*8-1:0] data_out;

    integer                 seed = 32'h8ded74ff;
    int                     error_count = 0;
    int                     cyc = 0;
    logic                   checking = 1'b0;
    logic                   pending = 1'b0;
    int                     req_cyc = 0;
    int                     req_size = 0;
    logic [MAX_BYTES*8-1:0] exp_word = '0;
    logic [MAX_BYTES*8-1:0] last_word = '0;
    byte_t                  shadow [DISK_BYTES];

    disk_subsys #(
        .BANK_ADDR_W (BANK_ADDR_W),
        .NUM_BANKS   (NUM_BANKS),
        .MAX_BYTES   (MAX_BYTES)
    ) dut_i (
        .clk      (clk),
        .RST      (RST),
        .wr       (wr),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .rd_size  (rd_size),
        .busy     (busy),
        .done     (done),
        .data_out (data_out)
    );

    task automatic report_failure();
        error_count++;
        $display("Finished with errors");
        $fatal(1);
    endtask

    `include "tb_disk_checks.svh"

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // Bytes from the shadow copy, wrapping at the end of the disk, zeros above the size.
    function automatic logic [MAX_BYTES*8-1:0] expected_read(
        input logic [ADDR_W-1:0] addr,
        input logic [SIZE_W-1:0] size
    );
        logic [MAX_BYTES*8-1:0] word;
        word = '0;
        for (int i = 0; i <= int'(size); i++) begin
            word[i*8 +: 8] = shadow[(int'(addr) + i) % DISK_BYTES];
        end
        return word;
    endfunction

    task automatic write_byte(input logic [ADDR_W-1:0] addr, input byte_t data);
        wr      = 1'b1;
        wr_addr = addr;
        wr_data = data;
        shadow[addr] = data;
        @(posedge clk);
        #DRIVE_DLY;
        wr = 1'b0;
    endtask

    // Issues one read and waits until the checker has seen its done.
    task automatic do_read(input logic [ADDR_W-1:0] addr, input logic [SIZE_W-1:0] size);
        int waited;
        exp_word = expected_read(addr, size);
        req_cyc  = cyc;
        req_size = int'(size);
        pending  = 1'b1;
        rd_req   = 1'b1;
        rd_addr  = addr;
        rd_size  = size;
        @(posedge clk);
        #DRIVE_DLY;
        rd_req = 1'b0;
        waited = 0;
        while (pending && waited < MAX_BYTES + 10) begin
            @(posedge clk);
            #DRIVE_DLY;
            waited++;
        end
        if (pending) begin
            $display("The read issued at cycle %0d never returned done", req_cyc);
            report_failure();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Checks status and result on every falling edge once reset is over.
    initial begin
        int due;
        wait (checking);
        forever begin
            @(negedge clk);
            due = req_cyc + req_size + 3;
            if (done && !pending) begin
                $display("done pulsed at time %0t with no read pending", $time);
                report_failure();
            end
            if (pending && cyc == due && !done) begin
                $display("done did not arrive %0d cycles after the read request",
                         req_size + 3);
                report_failure();
            end
            check_flag("busy", busy, pending && cyc > req_cyc && cyc < due);
            check_flag("done", done, pending && cyc == due);
            if (done) begin
                check_data("data_out", data_out, exp_word);
                last_word = exp_word;
                pending   = 1'b0;
            end else begin
                check_data("data_out", data_out, last_word);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("The simulation ran out of time before all reads completed");
        report_failure();
    end

    initial begin
        logic [ADDR_W-1:0] addr;
        logic [SIZE_W-1:0] size;
        int unsigned       bank;
        int unsigned       off;
        RST     = 1'b1;
        wr      = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_req  = 1'b0;
        rd_addr = '0;
        rd_size = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        RST = 1'b0;
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_data("data_out", data_out, '0);
        checking = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        for (int a = 0; a < DISK_BYTES; a++) begin
            write_byte(ADDR_W'(a), byte_t'(next_random()));
        end
        for (int t = 0; t < NUM_ALIGNED; t++) begin
            size = SIZE_W'(next_random());
            bank = next_random() % NUM_BANKS;
            off  = next_random() % (BANK_BYTES - int'(size));
            do_read(ADDR_W'(bank * BANK_BYTES + off), size);
        end
        // The first segment holds 1 to size bytes, so each read crosses into the next bank.
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int s = 0; s < SPLITS_PER_BANK; s++) begin
                size = SIZE_W'(1 + next_random() % (MAX_BYTES - 1));
                off  = BANK_BYTES - 1 - next_random() % size;
                do_read(ADDR_W'(b * BANK_BYTES + off), size);
            end
        end
        for (int t = 0; t < NUM_REWRITE; t++) begin
            addr = ADDR_W'(next_random());
            size = SIZE_W'(next_random());
            repeat (3) begin
                off = next_random() % (int'(size) + 1);
                write_byte(ADDR_W'(addr + off), byte_t'(next_random()));
            end
            do_read(addr, size);
        end
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
